/* memPkg.sv */
//******************************
// memory stage definitions
//******************************
`default_nettype none

package memPkg;

    localparam int DataWidth  = 32;
    localparam int RegAddrW   = 5;
    localparam int ExcCodeW   = 5;
    localparam int WbSelW     = 2;

    localparam int RamWords   = 64;
    localparam int RamAw      = $clog2(RamWords);    // word index from addr bits 7:2

    // direct-mapped, one word per line
    localparam int CacheLines = 8;
    localparam int CacheIdxW  = $clog2(CacheLines);  // addr bits 4:2
    localparam int CacheTagW  = DataWidth - CacheIdxW - 2;

    localparam logic [2:0] UncachedSeg = 3'b101;     // kseg1-style window

    localparam logic [WbSelW-1:0] WbSelAlu  = 2'd0;
    localparam logic [WbSelW-1:0] WbSelLoad = 2'd1;
    localparam logic [WbSelW-1:0] WbSelCp0  = 2'd2;

    // Cause ExcCode values; ExcNone only means something with a valid flag
    localparam logic [ExcCodeW-1:0] ExcNone = 5'd0;
    localparam logic [ExcCodeW-1:0] ExcInt  = 5'd0;
    localparam logic [ExcCodeW-1:0] ExcAdEL = 5'd4;
    localparam logic [ExcCodeW-1:0] ExcAdES = 5'd5;

    localparam int StatusIe  = 0;
    localparam int StatusExl = 1;
    localparam int ImLo      = 8;   // Status IM and Cause IP share 15:8
    localparam int ImHi      = 15;

endpackage

`default_nettype wire

/* memReg.sv */
//******************************
// memory stage register
//******************************
`timescale 1ns/10ps
`default_nettype none

module memReg (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          memWr,
    input  logic                          memFlush,
    input  logic [memPkg::DataWidth-1:0]  exeAluOut,
    input  logic [memPkg::DataWidth-1:0]  exeOutB,
    input  logic [memPkg::RegAddrW-1:0]   exeDst,
    input  logic                          exeRegWr,
    input  logic                          exeLoad,
    input  logic                          exeStore,
    input  logic [memPkg::WbSelW-1:0]     exeWbSel,
    input  logic [memPkg::DataWidth-1:0]  exePc,
    input  logic [memPkg::DataWidth-1:0]  cp0Bus,
    input  logic                          excValid,
    input  logic                          cacheDone,
    input  logic [memPkg::DataWidth-1:0]  cacheRdata,
    input  logic                          uncDone,
    input  logic [memPkg::DataWidth-1:0]  uncRdata,
    output logic [memPkg::DataWidth-1:0]  memAddr,
    output logic                          memLoad,
    output logic                          memStore,
    output logic [memPkg::DataWidth-1:0]  memPc,
    output logic                          stageValid,
    output logic                          cacheReq,
    output logic                          uncReq,
    output logic [memPkg::DataWidth-1:0]  reqAddr,
    output logic                          reqWrite,
    output logic [memPkg::DataWidth-1:0]  reqWdata,
    output logic                          stall,
    output logic                          wbValid,
    output logic [memPkg::RegAddrW-1:0]   wbDst,
    output logic                          wbRegWr,
    output logic [memPkg::DataWidth-1:0]  wbResult,
    output logic [memPkg::DataWidth-1:0]  fwdResult
);
    import memPkg::*;

    typedef enum logic [1:0] {StIdle, StWait, StDone} stateT;

    stateT                  state;
    logic                   held;        // stage holds an instruction
    logic [DataWidth-1:0]   memOutB;
    logic [RegAddrW-1:0]    memDst;
    logic                   memRegWr;
    logic [WbSelW-1:0]      memWbSel;
    logic                   access;
    logic                   uncRegion;
    logic                   issue;
    logic                   peerDone;
    logic                   accDone;
    logic                   capture;
    logic                   retireNow;
    logic [DataWidth-1:0]   loadData;
    logic [DataWidth-1:0]   selResult;

    assign access     = memLoad | memStore;
    assign uncRegion  = memAddr[DataWidth-1 -: 3] == UncachedSeg;
    // exceptions are only looked at before the access goes out
    assign stageValid = held & (state != StWait);
    assign issue      = stageValid & access & ~excValid;
    assign peerDone   = cacheDone | uncDone;
    assign accDone    = (state == StWait) & peerDone;
    assign retireNow  = stageValid & ~access & ~excValid;   // no memory access
    assign capture    = memWr & ~stall & ~memFlush;

    assign cacheReq = issue & ~uncRegion;
    assign uncReq   = issue & uncRegion;
    assign reqAddr  = memAddr;
    assign reqWrite = memStore;
    assign reqWdata = memOutB;
    assign stall    = issue | ((state == StWait) & ~peerDone);

    assign loadData  = cacheDone ? cacheRdata : uncRdata;
    assign fwdResult = (memWbSel == WbSelCp0) ? cp0Bus : memAddr;   // bypass while pending

    always_comb begin
        case (memWbSel)
            WbSelAlu:  selResult = memAddr;
            WbSelLoad: selResult = loadData;
            default:   selResult = cp0Bus;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            held    <= 1'b0;
            state   <= StIdle;
            wbValid <= 1'b0;
        end else begin
            wbValid <= retireNow | (held & accDone);   // a flushed access retires silently
            if (capture)
                held <= 1'b1;
            else if (memFlush | (stageValid & ~issue) | accDone)
                held <= 1'b0;
            case (state)
                StWait:  if (peerDone) state <= StDone;
                default: state <= issue ? StWait : StIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            memAddr  <= exeAluOut;
            memOutB  <= exeOutB;
            memDst   <= exeDst;
            memRegWr <= exeRegWr;
            memLoad  <= exeLoad;
            memStore <= exeStore;
            memWbSel <= exeWbSel;
            memPc    <= exePc;
        end
        if (retireNow | accDone) begin
            wbDst    <= memDst;
            wbRegWr  <= memRegWr;
            wbResult <= selResult;
        end
    end

endmodule

`default_nettype wire

/* exceptUnit.sv */
//******************************
// memory stage exceptions
//******************************
`timescale 1ns/10ps
`default_nettype none

module exceptUnit (
    input  logic                          stageValid,
    input  logic [memPkg::DataWidth-1:0]  memAddr,
    input  logic                          memLoad,
    input  logic                          memStore,
    input  logic [memPkg::DataWidth-1:0]  memPc,
    input  logic [memPkg::DataWidth-1:0]  cp0Status,
    input  logic [memPkg::DataWidth-1:0]  cp0Cause,
    input  logic                          clk,
    input  logic                          rstN,
    output logic                          excValid,
    output logic [memPkg::ExcCodeW-1:0]   excCode,
    output logic                          exceptFlush,
    output logic [memPkg::DataWidth-1:0]  excPc
);
    import memPkg::*;

    logic                 intPending;
    logic                 misaligned;
    logic [ExcCodeW-1:0]  codeNow;

    assign intPending = cp0Status[StatusIe] & ~cp0Status[StatusExl]
                      & (|(cp0Status[ImHi:ImLo] & cp0Cause[ImHi:ImLo]));
    assign misaligned = (memLoad | memStore) & (|memAddr[1:0]);   // word accesses only
    assign excValid   = stageValid & (intPending | misaligned);

    // interrupt wins over an address error
    always_comb begin
        if (!excValid)
            codeNow = ExcNone;
        else if (intPending)
            codeNow = ExcInt;
        else if (memLoad)
            codeNow = ExcAdEL;
        else
            codeNow = ExcAdES;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exceptFlush <= 1'b0;
            excCode     <= ExcNone;
        end else begin
            exceptFlush <= excValid;   // one-cycle pulse
            excCode     <= codeNow;
        end
    end

    always_ff @(posedge clk) begin
        excPc <= memPc;
    end

endmodule

`default_nettype wire

/* dataCache.sv */
//******************************
// write-through data cache
//******************************
`timescale 1ns/10ps
`default_nettype none

module dataCache (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          cacheReq,
    input  logic [memPkg::DataWidth-1:0]  reqAddr,
    input  logic                          reqWrite,
    input  logic [memPkg::DataWidth-1:0]  reqWdata,
    input  logic                          cRamAck,
    input  logic [memPkg::DataWidth-1:0]  ramRdata,
    output logic                          cacheDone,
    output logic [memPkg::DataWidth-1:0]  cacheRdata,
    output logic                          cRamReq,
    output logic [memPkg::DataWidth-1:0]  cRamAddr,
    output logic                          cRamWe,
    output logic [memPkg::DataWidth-1:0]  cRamWdata
);
    import memPkg::*;

    logic [CacheLines-1:0]  lineValid;
    logic [CacheTagW-1:0]   tagArr  [CacheLines];
    logic [DataWidth-1:0]   dataArr [CacheLines];
    logic [CacheIdxW-1:0]   reqIdx;
    logic [CacheIdxW-1:0]   fillIdx;
    logic [CacheTagW-1:0]   reqTag;
    logic                   hit;
    logic                   hitDone;
    logic [DataWidth-1:0]   hitData;

    assign reqIdx  = reqAddr[CacheIdxW+1:2];
    assign reqTag  = reqAddr[DataWidth-1:CacheIdxW+2];
    assign fillIdx = cRamAddr[CacheIdxW+1:2];   // line of the access in flight
    assign hit     = lineValid[reqIdx] & (tagArr[reqIdx] == reqTag);

    assign cacheDone  = hitDone | cRamAck;
    assign cacheRdata = cRamAck ? ramRdata : hitData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lineValid <= '0;
            cRamReq   <= 1'b0;
            hitDone   <= 1'b0;
        end else begin
            hitDone <= cacheReq & ~reqWrite & hit;
            // stores always go through, loads only on a miss
            if (cacheReq & (reqWrite | ~hit))
                cRamReq <= 1'b1;
            else if (cRamAck)
                cRamReq <= 1'b0;
            if (cRamAck & ~cRamWe)
                lineValid[fillIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cacheReq) begin
            cRamAddr  <= reqAddr;
            cRamWe    <= reqWrite;
            cRamWdata <= reqWdata;
            hitData   <= dataArr[reqIdx];
        end
        if (cacheReq & reqWrite & hit)
            dataArr[reqIdx] <= reqWdata;   // store miss does not allocate
        if (cRamAck & ~cRamWe) begin
            dataArr[fillIdx] <= ramRdata;
            tagArr[fillIdx]  <= cRamAddr[DataWidth-1:CacheIdxW+2];
        end
    end

endmodule

`default_nettype wire

/* uncacheUnit.sv */
//******************************
// uncached access unit
//******************************
`timescale 1ns/10ps
`default_nettype none

module uncacheUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          uncReq,
    input  logic [memPkg::DataWidth-1:0]  reqAddr,
    input  logic                          reqWrite,
    input  logic [memPkg::DataWidth-1:0]  reqWdata,
    input  logic                          uRamAck,
    input  logic [memPkg::DataWidth-1:0]  ramRdata,
    output logic                          uncDone,
    output logic [memPkg::DataWidth-1:0]  uncRdata,
    output logic                          uRamReq,
    output logic [memPkg::DataWidth-1:0]  uRamAddr,
    output logic                          uRamWe,
    output logic [memPkg::DataWidth-1:0]  uRamWdata
);
    import memPkg::*;

    logic                  pend;       // request taken, not yet answered
    logic                  pWe;
    logic [DataWidth-1:0]  pAddr;
    logic [DataWidth-1:0]  pData;
    logic                  bufValid;   // posted store waiting to drain
    logic [DataWidth-1:0]  bufAddr;
    logic [DataWidth-1:0]  bufData;
    logic                  bufLoad;

    assign bufLoad = pend & pWe & ~bufValid;
    // a load behind a full buffer waits for the drain
    assign uncDone = bufLoad | (pend & ~pWe & ~bufValid & uRamAck);
    assign uncRdata = ramRdata;

    assign uRamReq   = bufValid | (pend & ~pWe);
    assign uRamWe    = bufValid;
    assign uRamAddr  = bufValid ? bufAddr : pAddr;
    assign uRamWdata = bufData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pend     <= 1'b0;
            bufValid <= 1'b0;
        end else begin
            if (uncReq)
                pend <= 1'b1;
            else if (uncDone)
                pend <= 1'b0;
            if (bufLoad)
                bufValid <= 1'b1;
            else if (uRamAck & bufValid)
                bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (uncReq) begin
            pAddr <= reqAddr;
            pWe   <= reqWrite;
            pData <= reqWdata;
        end
        if (bufLoad) begin
            bufAddr <= pAddr;
            bufData <= pData;
        end
    end

endmodule

`default_nettype wire

/* memBusArbiter.sv */
//******************************
// shared RAM port arbiter
//******************************
`timescale 1ns/10ps
`default_nettype none

module memBusArbiter (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          cRamReq,
    input  logic [memPkg::DataWidth-1:0]  cRamAddr,
    input  logic                          cRamWe,
    input  logic [memPkg::DataWidth-1:0]  cRamWdata,
    input  logic                          uRamReq,
    input  logic [memPkg::DataWidth-1:0]  uRamAddr,
    input  logic                          uRamWe,
    input  logic [memPkg::DataWidth-1:0]  uRamWdata,
    input  logic                          ramAck,
    output logic                          cRamAck,
    output logic                          uRamAck,
    output logic                          ramEn,
    output logic                          ramWe,
    output logic [memPkg::DataWidth-1:0]  ramAddr,
    output logic [memPkg::DataWidth-1:0]  ramWdata
);

    logic busy;   // grant held until the RAM acks
    logic ownU;
    logic selU;

    assign selU     = busy ? ownU : uRamReq;   // uncached peer first
    assign ramEn    = ~busy & (uRamReq | cRamReq);
    assign ramWe    = selU ? uRamWe : cRamWe;
    assign ramAddr  = selU ? uRamAddr : cRamAddr;
    assign ramWdata = selU ? uRamWdata : cRamWdata;

    assign uRamAck = ramAck & ownU;
    assign cRamAck = ramAck & ~ownU;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            ownU <= 1'b0;
        end else if (ramEn) begin
            busy <= 1'b1;
            ownU <= uRamReq;
        end else if (ramAck) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* dataRam.sv */
//******************************
// data RAM
//******************************
`timescale 1ns/10ps
`default_nettype none

module dataRam (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          ramEn,
    input  logic                          ramWe,
    input  logic [memPkg::DataWidth-1:0]  ramAddr,
    input  logic [memPkg::DataWidth-1:0]  ramWdata,
    output logic                          ramAck,
    output logic [memPkg::DataWidth-1:0]  ramRdata
);
    import memPkg::*;

    logic [DataWidth-1:0]  mem [RamWords];
    logic [RamAw-1:0]      wordIdx;

    assign wordIdx = ramAddr[RamAw+1:2];   // segment bits ignored, kseg1 aliases

    always_ff @(posedge clk) begin
        if (!rstN)
            ramAck <= 1'b0;
        else
            ramAck <= ramEn;
    end

    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe)
                mem[wordIdx] <= ramWdata;
            ramRdata <= mem[wordIdx];   // old word on a write
        end
    end

endmodule

`default_nettype wire

/* memStage.sv */
//******************************
// memory stage top
//******************************
`timescale 1ns/10ps
`default_nettype none

module memStage (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          memWr,
    input  logic                          memFlush,
    input  logic [memPkg::DataWidth-1:0]  exeAluOut,
    input  logic [memPkg::DataWidth-1:0]  exeOutB,
    input  logic [memPkg::RegAddrW-1:0]   exeDst,
    input  logic                          exeRegWr,
    input  logic                          exeLoad,
    input  logic                          exeStore,
    input  logic [memPkg::WbSelW-1:0]     exeWbSel,
    input  logic [memPkg::DataWidth-1:0]  exePc,
    input  logic [memPkg::DataWidth-1:0]  cp0Status,
    input  logic [memPkg::DataWidth-1:0]  cp0Cause,
    input  logic [memPkg::DataWidth-1:0]  cp0Bus,
    output logic                          stall,
    output logic [memPkg::DataWidth-1:0]  fwdResult,
    output logic                          wbValid,
    output logic [memPkg::RegAddrW-1:0]   wbDst,
    output logic                          wbRegWr,
    output logic [memPkg::DataWidth-1:0]  wbResult,
    output logic                          exceptFlush,
    output logic [memPkg::ExcCodeW-1:0]   excCode,
    output logic [memPkg::DataWidth-1:0]  excPc
);
    import memPkg::*;

    // stage to exception check
    logic [DataWidth-1:0]  memAddr;
    logic [DataWidth-1:0]  memPc;
    logic                  memLoad, memStore;
    logic                  stageValid, excValid;

    // stage to peers
    logic                  cacheReq, uncReq, reqWrite;
    logic [DataWidth-1:0]  reqAddr, reqWdata;
    logic                  cacheDone, uncDone;
    logic [DataWidth-1:0]  cacheRdata, uncRdata;

    // peers to RAM
    logic                  cRamReq, cRamWe, cRamAck;
    logic [DataWidth-1:0]  cRamAddr, cRamWdata;
    logic                  uRamReq, uRamWe, uRamAck;
    logic [DataWidth-1:0]  uRamAddr, uRamWdata;
    logic                  ramEn, ramWe, ramAck;
    logic [DataWidth-1:0]  ramAddr, ramWdata, ramRdata;

    memReg        uMemReg   (.*);
    exceptUnit    uExcept   (.*);
    dataCache     uCache    (.*);
    uncacheUnit   uUncache  (.*);
    memBusArbiter uArbiter  (.*);
    dataRam       uRam      (.*);

endmodule

`default_nettype wire

/* tb_memStage.sv */
//******************************
// memory stage testbench
//******************************
`timescale 1ns/10ps
`default_nettype none

module tb_memStage;

    // op codes 0 none 1 load 2 store
    // sel codes 0 alu 1 load 2 cp0
    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  sel;
        logic [31:0] status;
        logic [31:0] cause;
        logic        flush;
        logic [7:0]  expCode;   // ff for a normal retire
    } caseT;

    logic        clk;
    logic        rstN;
    logic        memWr;
    logic        memFlush;
    logic [31:0] exeAluOut;
    logic [31:0] exeOutB;
    logic [4:0]  exeDst;
    logic        exeRegWr;
    logic        exeLoad;
    logic        exeStore;
    logic [1:0]  exeWbSel;
    logic [31:0] exePc;
    logic [31:0] cp0Status;
    logic [31:0] cp0Cause;
    logic [31:0] cp0Bus;
    logic        stall;
    logic [31:0] fwdResult;
    logic        wbValid;
    logic [4:0]  wbDst;
    logic        wbRegWr;
    logic [31:0] wbResult;
    logic        exceptFlush;
    logic [4:0]  excCode;
    logic [31:0] excPc;

    caseT        cases[$];
    logic [31:0] refMem [64];   // word model indexed by addr bits 7:2
    logic [63:0] written;
    int          numCases;

    memStage memStage_inst (.*);

    always #10 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else failRun($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    function automatic logic [31:0] expectedResult(input caseT c);
        case (c.sel)
            2'd0:    return c.addr;                // alu value is the address
            2'd1:    return refMem[c.addr[7:2]];
            default: return c.data;                // cp0Bus
        endcase
    endfunction

    task automatic readCases();
        int          fd;
        int          rc;
        string       line;
        caseT        c;
        logic [31:0] op, addr, data, sel, st, ca, fl, ex;
        fd = $fopen("memStage_cases.txt", "r");
        assert (fd != 0)
        else failRun("could not open memStage_cases.txt");
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc != 0 && $sscanf(line, "%h %h %h %h %h %h %h %h",
                                   op, addr, data, sel, st, ca, fl, ex) == 8) begin
                c.op      = op[1:0];
                c.addr    = addr;
                c.data    = data;
                c.sel     = sel[1:0];
                c.status  = st;
                c.cause   = ca;
                c.flush   = fl[0];
                c.expCode = ex[7:0];
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic runCase(input caseT c, input int idx);
        logic [31:0] stData;
        logic [31:0] pc;
        logic [4:0]  dst;
        logic        isAccess;   // goes out to a peer
        int          waited;
        stData = $urandom();
        pc     = 32'h0040_0000 + 32'(idx) * 32'd4;
        dst    = idx[4:0];
        isAccess = (c.op != 2'd0) && (c.expCode == 8'hff);
        waited   = 0;
        @(posedge clk);
        exeAluOut <= c.addr;
        exeOutB   <= stData;
        exeDst    <= dst;
        exeRegWr  <= (c.op != 2'd2);
        exeLoad   <= (c.op == 2'd1);
        exeStore  <= (c.op == 2'd2);
        exeWbSel  <= c.sel;
        exePc     <= pc;
        cp0Status <= c.status;
        cp0Cause  <= c.cause;
        cp0Bus    <= c.data;
        memWr     <= 1'b1;
        memFlush  <= c.flush;
        @(posedge clk);                 // capture edge
        memWr    <= 1'b0;
        memFlush <= 1'b0;
        if (c.flush) begin
            repeat (6) begin
                @(negedge clk);
                assert (!wbValid && !exceptFlush)
                else failRun($sformatf("case %0d was flushed but still finished", idx));
            end
        end else begin
            @(negedge clk);
            waited = 1;
            // stage holds the instruction now
            checkWord("fwdResult", fwdResult, (c.sel == 2'd2) ? c.data : c.addr);
            checkWord("stall", {31'b0, stall}, {31'b0, isAccess});
            while (!wbValid && !exceptFlush) begin
                @(negedge clk);          // latency varies with the access
                waited = waited + 1;
            end
            checkWord("stall", {31'b0, stall}, 32'b0);
            if (!isAccess) begin
                assert (waited == 2)
                else failRun($sformatf("case %0d ended %0d cycles after capture, not one",
                                       idx, waited - 1));
            end
            if (c.expCode == 8'hff) begin
                assert (wbValid && !exceptFlush)
                else failRun($sformatf("case %0d raised an exception it should not", idx));
                if (c.op == 2'd1) begin
                    assert (written[c.addr[7:2]])
                    else failRun($sformatf("case %0d loads a word never stored", idx));
                end
                checkWord("wbResult", wbResult, expectedResult(c));
                checkWord("wbDst", {27'b0, wbDst}, {27'b0, dst});
                checkWord("wbRegWr", {31'b0, wbRegWr}, {31'b0, c.op != 2'd2});
                if (c.op == 2'd2) begin
                    refMem[c.addr[7:2]]  = stData;
                    written[c.addr[7:2]] = 1'b1;
                end
            end else begin
                assert (exceptFlush && !wbValid)
                else failRun($sformatf("case %0d retired without its exception", idx));
                checkWord("excCode", {27'b0, excCode}, {27'b0, c.expCode[4:0]});
                checkWord("excPc", excPc, pc);
                repeat (4) begin
                    @(negedge clk);
                    assert (!wbValid)
                    else failRun($sformatf("case %0d wrote back after its exception", idx));
                end
            end
        end
    endtask

    // watchdog allows 40 cycles per case plus reset
    initial begin
        wait (numCases > 0);
        repeat (numCases * 40 + 4) @(posedge clk);
        $display("timeout after %0d cycles, the cases did not finish", numCases * 40 + 4);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h4cd2_c04b));
        clk       = 1'b0;
        rstN      = 1'b0;
        memWr     = 1'b0;
        memFlush  = 1'b0;
        exeAluOut = '0;
        exeOutB   = '0;
        exeDst    = '0;
        exeRegWr  = 1'b0;
        exeLoad   = 1'b0;
        exeStore  = 1'b0;
        exeWbSel  = '0;
        exePc     = '0;
        cp0Status = '0;
        cp0Cause  = '0;
        cp0Bus    = '0;
        written   = '0;
        readCases();
        numCases = cases.size();
        assert (numCases > 0)
        else failRun("memStage_cases.txt holds no cases");
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        foreach (cases[i])
            runCase(cases[i], i);
        repeat (4) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* memStage_cases.txt */
# op(0 none 1 load 2 store) addr data(cp0Bus) sel(0 alu 1 load 2 cp0) status cause flush expect
# expect ff is a normal retire, otherwise the exception code
2 00000010 00000000 0 00000000 00000000 0 ff
1 00000010 00000000 1 00000000 00000000 0 ff
1 00000010 00000000 1 00000000 00000000 0 ff
2 a0000024 00000000 0 00000000 00000000 0 ff
1 00000124 00000000 1 00000000 00000000 0 ff
1 a0000010 00000000 1 00000000 00000000 0 ff
0 12345678 00000000 0 00000000 00000000 0 ff
0 00000040 cafef00d 2 00000000 00000000 0 ff
1 00000012 00000000 1 00000000 00000000 0 04
2 00000011 00000000 0 00000000 00000000 0 05
1 a0000010 00000000 1 00000000 00000000 0 ff
1 00000010 00000000 1 00000401 00000400 0 00
1 00000010 00000000 1 00000403 00000400 0 ff
2 00000010 00000000 0 00000000 00000000 1 ff
1 a0000010 00000000 1 00000000 00000000 0 ff

/* memStage.f */
memPkg.sv
memReg.sv
exceptUnit.sv
dataCache.sv
uncacheUnit.sv
memBusArbiter.sv
dataRam.sv
memStage.sv
tb_memStage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memStage testbench with Verilator
set -u
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -f memStage.f --top-module tb_memStage -o Vtb_memStage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_memStage > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
exit 1
